//--- src/sa_pkg.sv
package sa_pkg;

  ////////////////////
  // array geometry
  ////////////////////

  // tile edge, rows and columns alike
  localparam int SIDE   = 8;
  localparam int ELEM_W = 8;
  localparam int WORD_W = 32;
  // int8 elements per dma word
  localparam int LANES  = WORD_W / ELEM_W;

  ////////////////////
  // buffer layout
  ////////////////////

  localparam int WORDS_PER_MATRIX = SIDE * SIDE / LANES;
  // a first, then b
  localparam int IN_WORDS  = 2 * WORDS_PER_MATRIX;
  // one accumulator per word
  localparam int OUT_WORDS = SIDE * SIDE;
  localparam int B_BASE    = WORDS_PER_MATRIX;
  localparam int IN_AW     = $clog2(IN_WORDS);
  localparam int OUT_AW    = $clog2(OUT_WORDS);

  // first injection to last accumulate in the far corner
  localparam int MATMUL_CYCLES = 3 * SIDE - 1;
  localparam int IDX_W         = $clog2(SIDE);

  typedef logic signed [ELEM_W-1:0] elem_t;
  typedef logic [WORD_W-1:0]        word_t;
  typedef logic signed [31:0]       acc_t;

  // run phases, in order of one job
  typedef enum logic [2:0] {
    PH_IDLE,
    PH_FETCH,
    PH_UNPACK,
    PH_MATMUL,
    PH_STORE,
    PH_DRAIN
  } phase_t;

endpackage

//--- src/word_buffer.sv
`timescale 1ns/100ps

module word_buffer #(
  parameter type data_t = logic [31:0],
  parameter int  AW     = 5
) (
  input  logic          clk,
  // write side
  input  logic          we,
  input  logic [AW-1:0] waddr,
  input  data_t         wdata,
  // read side, one cycle latency
  input  logic          re,
  input  logic [AW-1:0] raddr,
  output data_t         rdata
);

  // full power-of-two depth
  data_t mem [2**AW];

  ////////////////////
  // write port
  ////////////////////

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  ////////////////////
  // read port
  ////////////////////

  // output holds while re is low
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

//--- src/operand_loader.sv
`timescale 1ns/100ps

module operand_loader import sa_pkg::*; (
  input  logic             clk,
  input  logic             rstn,
  input  logic             unpack_go,
  // input buffer read port
  output logic             re,
  output logic [IN_AW-1:0] raddr,
  input  word_t            rdata,
  output logic             unpack_done,
  // a by row, b by column
  output elem_t            a_bank [SIDE][SIDE],
  output elem_t            b_bank [SIDE][SIDE]
);

  logic             busy;
  logic [IN_AW-1:0] rd_cnt;
  // word in flight from the buffer
  logic             wr_vld;
  logic [IN_AW-1:0] wr_idx;
  logic [IN_AW-1:0] mat_word;
  logic [IDX_W-1:0] row;
  logic [IDX_W-1:0] col_base;
  elem_t            lane_elem [LANES];

  ////////////////////
  // read walk
  ////////////////////

  assign re    = busy;
  assign raddr = rd_cnt;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy        <= 1'b0;
      rd_cnt      <= '0;
      wr_vld      <= 1'b0;
      wr_idx      <= '0;
      unpack_done <= 1'b0;
    end else begin
      // data comes back one cycle after the read
      wr_vld      <= re;
      wr_idx      <= raddr;
      // pulse once the last word lands in the banks
      unpack_done <= wr_vld && (wr_idx == IN_AW'(IN_WORDS - 1));
      if (unpack_go) begin
        busy   <= 1'b1;
        rd_cnt <= '0;
      end else if (busy) begin
        rd_cnt <= rd_cnt + 1'b1;
        if (rd_cnt == IN_AW'(IN_WORDS - 1)) begin
          busy <= 1'b0;
        end
      end
    end
  end

  ////////////////////
  // lane split
  ////////////////////

  // word index inside its own matrix
  assign mat_word = wr_idx % IN_AW'(WORDS_PER_MATRIX);
  // two words per matrix row
  assign row      = IDX_W'(mat_word / (SIDE / LANES));
  assign col_base = IDX_W'((mat_word % (SIDE / LANES)) * LANES);

  // lane 0 sits in the low byte
  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      lane_elem[l] = elem_t'(rdata[l*ELEM_W +: ELEM_W]);
    end
  end

  ////////////////////
  // bank fill
  ////////////////////

  // four elements per cycle
  always_ff @(posedge clk) begin
    if (wr_vld) begin
      for (int l = 0; l < LANES; l++) begin
        if (wr_idx < IN_AW'(B_BASE)) begin
          a_bank[row][int'(col_base) + l] <= lane_elem[l];
        end else begin
          // transposed, each b column kept together
          b_bank[int'(col_base) + l][row] <= lane_elem[l];
        end
      end
    end
  end

endmodule

//--- src/mac_pe.sv
`timescale 1ns/100ps

module mac_pe import sa_pkg::*; (
  input  logic  clk,
  input  logic  rstn,
  input  logic  clr,
  // from the left and from above
  input  elem_t a_in,
  input  elem_t b_in,
  input  logic  vld_in,
  // to the right and below
  output elem_t a_out,
  output elem_t b_out,
  output logic  vld_out,
  output acc_t  acc
);

  // full 16 bit signed product
  logic signed [2*ELEM_W-1:0] prod;

  assign prod = a_in * b_in;

  // operand hop, one cycle per pe
  always_ff @(posedge clk) begin
    a_out <= a_in;
    b_out <= b_in;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      vld_out <= 1'b0;
      acc     <= '0;
    end else begin
      // valid rides along with a
      vld_out <= vld_in;
      if (clr) begin
        acc <= '0;
      end else if (vld_in) begin
        // product sign extends into the sum
        acc <= acc + prod;
      end
    end
  end

endmodule

//--- src/systolic_grid.sv
`timescale 1ns/100ps

module systolic_grid import sa_pkg::*; (
  input  logic             clk,
  input  logic             rstn,
  input  logic             mm_go,
  input  elem_t            a_bank [SIDE][SIDE],
  input  elem_t            b_bank [SIDE][SIDE],
  // result select, used by the store walk
  input  logic [IDX_W-1:0] res_row,
  input  logic [IDX_W-1:0] res_col,
  output acc_t             res
);

  logic                          run;
  logic [$clog2(MATMUL_CYCLES)-1:0] step;
  // skew values for this step
  elem_t                         a_inj [SIDE];
  elem_t                         b_inj [SIDE];
  logic [SIDE-1:0]               v_inj;
  // edge registers
  elem_t                         a_edge [SIDE];
  elem_t                         b_edge [SIDE];
  logic [SIDE-1:0]               v_edge;
  // mesh nets, one extra column and row for the far edges
  elem_t                         a_h [SIDE][SIDE+1];
  logic                          v_h [SIDE][SIDE+1];
  elem_t                         b_v [SIDE+1][SIDE];
  acc_t                          acc_grid [SIDE][SIDE];

  ////////////////////
  // step counter
  ////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      run  <= 1'b0;
      step <= '0;
    end else if (mm_go) begin
      run  <= 1'b1;
      step <= '0;
    end else if (run) begin
      step <= step + 1'b1;
      if (int'(step) == MATMUL_CYCLES - 1) begin
        run <= 1'b0;
      end
    end
  end

  ////////////////////
  // skewed injection
  ////////////////////

  // row i gets A[i][t-i], column j gets B[t-j][j]
  always_comb begin
    for (int i = 0; i < SIDE; i++) begin
      a_inj[i] = '0;
      b_inj[i] = '0;
      v_inj[i] = 1'b0;
      if (run && int'(step) >= i && int'(step) - i < SIDE) begin
        a_inj[i] = a_bank[i][int'(step) - i];
        v_inj[i] = 1'b1;
        // b_bank is stored by column
        b_inj[i] = b_bank[i][int'(step) - i];
      end
    end
  end

  always_ff @(posedge clk) begin
    a_edge <= a_inj;
    b_edge <= b_inj;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      v_edge <= '0;
    end else begin
      v_edge <= v_inj;
    end
  end

  ////////////////////
  // pe mesh
  ////////////////////

  for (genvar e = 0; e < SIDE; e++) begin : g_edge
    assign a_h[e][0] = a_edge[e];
    assign v_h[e][0] = v_edge[e];
    assign b_v[0][e] = b_edge[e];
  end

  for (genvar i = 0; i < SIDE; i++) begin : g_row
    for (genvar j = 0; j < SIDE; j++) begin : g_col
      mac_pe u_pe (
        .clk     (clk),
        .rstn    (rstn),
        .clr     (mm_go),
        .a_in    (a_h[i][j]),
        .b_in    (b_v[i][j]),
        .vld_in  (v_h[i][j]),
        .a_out   (a_h[i][j+1]),
        .b_out   (b_v[i+1][j]),
        .vld_out (v_h[i][j+1]),
        .acc     (acc_grid[i][j])
      );
    end
  end

  // registered result pick
  always_ff @(posedge clk) begin
    res <= acc_grid[res_row][res_col];
  end

endmodule

//--- src/sa_sequencer.sv
`timescale 1ns/100ps

module sa_sequencer import sa_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  input  logic              start,
  input  logic              read_vld,
  input  logic              wr_pull,
  input  logic              wr_done,
  input  logic              unpack_done,
  output logic              fetch_we,
  output logic              unpack_go,
  output logic              mm_go,
  output logic [IDX_W-1:0]  res_row,
  output logic [IDX_W-1:0]  res_col,
  output logic              store_we,
  output logic [OUT_AW-1:0] store_addr,
  output logic              out_re,
  output logic [OUT_AW-1:0] dma_cnt,
  output logic              rd_start,
  output logic              wr_start,
  output logic              done
);

  phase_t                                phase;
  // compute timer, covers mm_go plus the grid run
  logic [$clog2(MATMUL_CYCLES+1)-1:0]    mm_timer;
  // store walk, one past the last word ends it
  logic [$clog2(OUT_WORDS+1)-1:0]        st_cnt;

  ////////////////////
  // strobes to buffers
  ////////////////////

  // write address is dma_cnt
  assign fetch_we = (phase == PH_FETCH) && read_vld;
  assign out_re   = (phase == PH_DRAIN);

  // row major walk of the grid
  assign res_row = IDX_W'(st_cnt / SIDE);
  assign res_col = IDX_W'(st_cnt % SIDE);

  ////////////////////
  // phase fsm
  ////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      phase      <= PH_IDLE;
      dma_cnt    <= '0;
      mm_timer   <= '0;
      st_cnt     <= '0;
      store_we   <= 1'b0;
      store_addr <= '0;
      unpack_go  <= 1'b0;
      mm_go      <= 1'b0;
      rd_start   <= 1'b0;
      wr_start   <= 1'b0;
      done       <= 1'b0;
    end else begin
      // pulses default low
      unpack_go <= 1'b0;
      mm_go     <= 1'b0;
      rd_start  <= 1'b0;
      wr_start  <= 1'b0;
      done      <= 1'b0;
      // write lags the select by the grid result register
      store_we   <= (phase == PH_STORE) && (st_cnt < OUT_WORDS);
      store_addr <= OUT_AW'(st_cnt);

      case (phase)
        PH_IDLE: begin
          dma_cnt <= '0;
          if (start) begin
            rd_start <= 1'b1;
            phase    <= PH_FETCH;
          end
        end

        PH_FETCH: begin
          // gaps between strobes just wait
          if (read_vld) begin
            dma_cnt <= dma_cnt + 1'b1;
            if (dma_cnt == OUT_AW'(IN_WORDS - 1)) begin
              dma_cnt   <= '0;
              unpack_go <= 1'b1;
              phase     <= PH_UNPACK;
            end
          end
        end

        PH_UNPACK: begin
          if (unpack_done) begin
            mm_go    <= 1'b1;
            mm_timer <= '0;
            phase    <= PH_MATMUL;
          end
        end

        PH_MATMUL: begin
          // same length as the grid counter, plus the clear cycle
          mm_timer <= mm_timer + 1'b1;
          if (int'(mm_timer) == MATMUL_CYCLES) begin
            st_cnt <= '0;
            phase  <= PH_STORE;
          end
        end

        PH_STORE: begin
          st_cnt <= st_cnt + 1'b1;
          if (st_cnt == OUT_WORDS) begin
            st_cnt   <= '0;
            dma_cnt  <= '0;
            wr_start <= 1'b1;
            phase    <= PH_DRAIN;
          end
        end

        PH_DRAIN: begin
          // the write dma sets the pace
          if (wr_pull) begin
            dma_cnt <= dma_cnt + 1'b1;
          end
          if (wr_done) begin
            dma_cnt <= '0;
            done    <= 1'b1;
            phase   <= PH_IDLE;
          end
        end

        default: begin
          phase <= PH_IDLE;
        end
      endcase
    end
  end

endmodule

//--- src/sa_core.sv
`timescale 1ns/100ps

module sa_core import sa_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  input  logic              start,
  // read dma
  input  logic              read_vld,
  input  word_t             data_in,
  // write dma
  input  logic              wr_pull,
  input  logic              wr_done,
  output logic              rd_start,
  output logic              wr_start,
  output logic [OUT_AW-1:0] dma_cnt,
  output word_t             data_out,
  output logic              done
);

  logic              fetch_we;
  logic              in_re;
  logic [IN_AW-1:0]  in_raddr;
  word_t             in_rdata;
  logic              unpack_go;
  logic              unpack_done;
  logic              mm_go;
  elem_t             a_bank [SIDE][SIDE];
  elem_t             b_bank [SIDE][SIDE];
  logic [IDX_W-1:0]  res_row;
  logic [IDX_W-1:0]  res_col;
  acc_t              res;
  logic              store_we;
  logic [OUT_AW-1:0] store_addr;
  logic              out_re;
  acc_t              out_rdata;

  ////////////////////
  // input side
  ////////////////////

  // 32 packed words, a then b
  word_buffer #(
    .data_t (word_t),
    .AW     (IN_AW)
  ) u_in_buf (
    .clk   (clk),
    .we    (fetch_we),
    .waddr (dma_cnt[IN_AW-1:0]),
    .wdata (data_in),
    .re    (in_re),
    .raddr (in_raddr),
    .rdata (in_rdata)
  );

  operand_loader u_loader (
    .clk         (clk),
    .rstn        (rstn),
    .unpack_go   (unpack_go),
    .re          (in_re),
    .raddr       (in_raddr),
    .rdata       (in_rdata),
    .unpack_done (unpack_done),
    .a_bank      (a_bank),
    .b_bank      (b_bank)
  );

  ////////////////////
  // compute
  ////////////////////

  systolic_grid u_grid (
    .clk     (clk),
    .rstn    (rstn),
    .mm_go   (mm_go),
    .a_bank  (a_bank),
    .b_bank  (b_bank),
    .res_row (res_row),
    .res_col (res_col),
    .res     (res)
  );

  sa_sequencer u_seq (
    .clk         (clk),
    .rstn        (rstn),
    .start       (start),
    .read_vld    (read_vld),
    .wr_pull     (wr_pull),
    .wr_done     (wr_done),
    .unpack_done (unpack_done),
    .fetch_we    (fetch_we),
    .unpack_go   (unpack_go),
    .mm_go       (mm_go),
    .res_row     (res_row),
    .res_col     (res_col),
    .store_we    (store_we),
    .store_addr  (store_addr),
    .out_re      (out_re),
    .dma_cnt     (dma_cnt),
    .rd_start    (rd_start),
    .wr_start    (wr_start),
    .done        (done)
  );

  ////////////////////
  // output side
  ////////////////////

  // 64 results, one per word
  word_buffer #(
    .data_t (acc_t),
    .AW     (OUT_AW)
  ) u_out_buf (
    .clk   (clk),
    .we    (store_we),
    .waddr (store_addr),
    .wdata (res),
    .re    (out_re),
    .raddr (dma_cnt),
    .rdata (out_rdata)
  );

  // second stage after the buffer read
  always_ff @(posedge clk) begin
    data_out <= out_rdata;
  end

endmodule

//--- tests/tb_sa_model.svh
`ifndef TB_SA_MODEL_SVH
`define TB_SA_MODEL_SVH

// operand patterns for one matrix
typedef enum int {
  MK_IDENT,
  MK_RAND,
  MK_POS,
  MK_NEG,
  MK_MIXED
} mat_kind_t;

logic [31:0] rng_state;
// operands and the expected product, plain ints
int          a_mat [SIDE][SIDE];
int          b_mat [SIDE][SIDE];
int          c_ref [SIDE][SIDE];

////////////////////
// random source
////////////////////

function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// signed byte from the middle of the state
function automatic int rand_elem();
  rng_state = xorshift32(rng_state);
  return int'($signed(rng_state[15:8]));
endfunction

////////////////////
// matrices
////////////////////

function automatic int elem_value(input mat_kind_t kind, input int r, input int c);
  case (kind)
    MK_IDENT: return (r == c) ? 1 : 0;
    MK_POS:   return 127;
    MK_NEG:   return -128;
    // checkerboard, even cells positive
    MK_MIXED: return ((r + c) % 2 == 0) ? (rand_elem() & 127) : -((rand_elem() & 127) + 1);
    default:  return rand_elem();
  endcase
endfunction

// four elements per word, lane 0 in the low byte
function automatic word_t pack_word(input int w);
  word_t       word;
  logic [31:0] v;
  int          e;
  word = '0;
  for (int l = 0; l < LANES; l++) begin
    e = (w % WORDS_PER_MATRIX) * LANES + l;
    v = (w < B_BASE) ? a_mat[e / SIDE][e % SIDE] : b_mat[e / SIDE][e % SIDE];
    word[l*ELEM_W +: ELEM_W] = v[7:0];
  end
  return word;
endfunction

// c = a x b, 32 bit signed sums
task automatic compute_ref();
  int sum;
  for (int r = 0; r < SIDE; r++) begin
    for (int c = 0; c < SIDE; c++) begin
      sum = 0;
      for (int k = 0; k < SIDE; k++) begin
        sum = sum + a_mat[r][k] * b_mat[k][c];
      end
      c_ref[r][c] = sum;
    end
  end
endtask

`endif

//--- tests/tb_sa_core.sv
`timescale 1ns/100ps

module tb_sa_core import sa_pkg::*; ();

  localparam int          CLK_HALF   = 20;
  localparam int          DRIVE_DLY  = 2;
  localparam logic [31:0] SEED       = 32'h7231_9d35;
  localparam int          WAIT_LIMIT = 200;
  localparam int          N_RUNS     = 7;

  logic              clk = 1'b0;
  logic              rstn;
  logic              start;
  logic              read_vld;
  word_t             data_in;
  logic              wr_pull;
  logic              wr_done;
  logic              rd_start;
  logic              wr_start;
  logic [OUT_AW-1:0] dma_cnt;
  word_t             data_out;
  logic              done;

  `include "tb_sa_model.svh"

  // one row per run
  typedef struct packed {
    mat_kind_t a_kind;
    mat_kind_t b_kind;
    int        rd_gap;
    int        pull_gap;
    bit        fixed_exp;
    bit [31:0] exp_word;
  } run_cfg_t;

  // a kind, b kind, read gap, pull spacing, constant result
  localparam run_cfg_t RUN_TBL [N_RUNS] = '{
    '{MK_IDENT, MK_RAND,  0, 3,  1'b0, 32'h0000_0000},
    '{MK_RAND,  MK_RAND,  1, 3,  1'b0, 32'h0000_0000},
    '{MK_RAND,  MK_RAND,  4, 5,  1'b0, 32'h0000_0000},
    '{MK_NEG,   MK_NEG,   0, 3,  1'b1, 32'h0002_0000},
    '{MK_POS,   MK_NEG,   2, 4,  1'b1, 32'hfffe_0400},
    '{MK_MIXED, MK_MIXED, 1, 7,  1'b0, 32'h0000_0000},
    '{MK_RAND,  MK_IDENT, 3, 12, 1'b0, 32'h0000_0000}
  };

  sa_core UUT (
    .clk      (clk),
    .rstn     (rstn),
    .start    (start),
    .read_vld (read_vld),
    .data_in  (data_in),
    .wr_pull  (wr_pull),
    .wr_done  (wr_done),
    .rd_start (rd_start),
    .wr_start (wr_start),
    .dma_cnt  (dma_cnt),
    .data_out (data_out),
    .done     (done)
  );

  always #CLK_HALF clk = ~clk;

  ////////////////////
  // helpers
  ////////////////////

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else
      stop_on_error($sformatf("FAIL %s got %08h expected %08h", name, got, want));
  endtask

  // outputs settle long before the drive point
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // nothing moves while idle
  task automatic check_quiet();
    check_word("rd_start", rd_start, 0);
    check_word("wr_start", wr_start, 0);
    check_word("done", done, 0);
    check_word("dma_cnt", dma_cnt, 0);
  endtask

  ////////////////////
  // one table entry
  ////////////////////

  task automatic run_entry(input int idx);
    run_cfg_t cfg;
    int       n;
    cfg = RUN_TBL[idx];
    for (int r = 0; r < SIDE; r++) begin
      for (int c = 0; c < SIDE; c++) begin
        a_mat[r][c] = elem_value(cfg.a_kind, r, c);
        b_mat[r][c] = elem_value(cfg.b_kind, r, c);
      end
    end
    compute_ref();

    // start pulse and a single rd_start cycle
    check_quiet();
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    check_word("rd_start", rd_start, 1);
    next_cycle();
    check_word("rd_start", rd_start, 0);

    // read dma with gap cycles before every word
    for (int w = 0; w < IN_WORDS; w++) begin
      for (int g = 0; g < cfg.rd_gap; g++) begin
        next_cycle();
        check_word("wr_start", wr_start, 0);
      end
      read_vld = 1'b1;
      data_in  = pack_word(w);
      next_cycle();
      read_vld = 1'b0;
      check_word("wr_start", wr_start, 0);
      check_word("dma_cnt", dma_cnt, (w == IN_WORDS - 1) ? 0 : w + 1);
    end
    // stray strobe after fetch must not land anywhere
    read_vld = 1'b1;
    data_in  = 32'hdead_beef;
    next_cycle();
    read_vld = 1'b0;
    data_in  = '0;

    n = 0;
    while (wr_start !== 1'b1 && n < WAIT_LIMIT) begin
      next_cycle();
      n++;
    end
    assert (wr_start === 1'b1) else
      stop_on_error("wr_start did not arrive after the fetch phase");
    check_word("dma_cnt", dma_cnt, 0);

    // write dma pulls one result at a time
    for (int k = 0; k < OUT_WORDS; k++) begin
      check_word("dma_cnt", dma_cnt, k);
      for (int c = 1; c < cfg.pull_gap; c++) begin
        next_cycle();
        check_word("wr_start", wr_start, 0);
        check_word("done", done, 0);
        // valid from the second edge until the pull
        if (c >= 2) begin
          check_word("data_out", data_out, c_ref[k / SIDE][k % SIDE]);
          if (cfg.fixed_exp) begin
            check_word("data_out", data_out, cfg.exp_word);
          end
          if (cfg.a_kind == MK_IDENT) begin
            check_word("data_out", data_out, b_mat[k / SIDE][k % SIDE]);
          end
        end
      end
      wr_pull = 1'b1;
      next_cycle();
      wr_pull = 1'b0;
    end
    // six bit counter wraps after 64 pulls
    check_word("dma_cnt", dma_cnt, 0);

    wr_done = 1'b1;
    next_cycle();
    wr_done = 1'b0;
    check_word("done", done, 1);
    next_cycle();
    check_quiet();
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin : main
    rstn      = 1'b0;
    start     = 1'b0;
    read_vld  = 1'b0;
    data_in   = '0;
    wr_pull   = 1'b0;
    wr_done   = 1'b0;
    rng_state = SEED;
    repeat (5) @(posedge clk);
    #DRIVE_DLY;
    rstn = 1'b1;
    // quiet until the first start
    repeat (4) begin
      next_cycle();
      check_quiet();
    end
    for (int i = 0; i < N_RUNS; i++) begin
      run_entry(i);
    end
    $display("Verification passed");
    $finish;
  end

  // bound from the slowest table row
  initial begin : watchdog
    int max_gap;
    int max_pull;
    int limit;
    max_gap  = 0;
    max_pull = 0;
    for (int i = 0; i < N_RUNS; i++) begin
      if (RUN_TBL[i].rd_gap > max_gap) begin
        max_gap = RUN_TBL[i].rd_gap;
      end
      if (RUN_TBL[i].pull_gap > max_pull) begin
        max_pull = RUN_TBL[i].pull_gap;
      end
    end
    limit = N_RUNS * (32 * (max_gap + 1) + 200 + 64 * max_pull) + 20;
    repeat (limit) @(posedge clk);
    stop_on_error("timeout, the tests did not finish within the expected number of cycles");
  end

endmodule

//--- flist.f
+incdir+tests
src/sa_pkg.sv
src/word_buffer.sv
src/operand_loader.sv
src/mac_pe.sv
src/systolic_grid.sv
src/sa_sequencer.sv
src/sa_core.sv
tests/tb_sa_core.sv
